//--- design/cnn_cfg_pkg.sv
/*
 * Layer engine configuration
 * Address map of the config port and the layout of the layer register
 */
`default_nettype none

package cnn_cfg_pkg;

    localparam int CFG_AWIDTH = 5;
    localparam int CFG_DWIDTH = 32;

    localparam logic [CFG_AWIDTH-1:0] LAYERS_CFG_ADDR = 5'h02;

    // One config word, msb first
    typedef struct packed {
        logic [CFG_DWIDTH-26:0] reserved;   // Pads the word to CFG_DWIDTH
        logic                   bypass;     // Skip ReLU
        logic [7:0]             pool_nb;    // Extra windows pooled
        logic [7:0]             shift;      // Rescale right shift
        logic [7:0]             unused;
    } layer_cfg_t;

    typedef struct packed {
        logic [CFG_AWIDTH-1:0] addr;
        layer_cfg_t            data;
    } cfg_write_t;

endpackage

`default_nettype wire

//--- design/cnn_data_pkg.sv
/*
 * Layer engine arithmetic
 * Fixed pixel, weight and accumulator widths and their signed types
 */
`default_nettype none

package cnn_data_pkg;

    localparam int IMG_WIDTH = 16;
    localparam int KER_WIDTH = 16;

    // Guard bits cover the lane and window sums
    localparam int ACC_WIDTH = IMG_WIDTH + KER_WIDTH + 4;

    typedef logic signed [IMG_WIDTH-1:0] pixel_t;
    typedef logic signed [KER_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

//--- design/group_add.sv
/*
 * Group adder tree
 * Pipelined sum of the lane accumulators, one register per level
 */
`timescale 1ns/10ps
`default_nettype none

module group_add #(
    parameter int GROUP_NB = 4
) (
    input  wire logic                               clk,
    input  wire cnn_data_pkg::acc_t [GROUP_NB-1:0]  up_data,
    output cnn_data_pkg::acc_t                      dn_data
);

    // Heap order, node k sums nodes 2k+1 and 2k+2, leaves are the inputs
    cnn_data_pkg::acc_t node [GROUP_NB-1];

    for (genvar k = 0; k < GROUP_NB - 1; k++) begin : g_node
        if (2 * k + 1 >= GROUP_NB - 1) begin : g_leaf
            always_ff @(posedge clk) begin
                node[k] <= up_data[2*k+2-GROUP_NB] + up_data[2*k+3-GROUP_NB];
            end
        end else begin : g_inner
            always_ff @(posedge clk) begin
                node[k] <= node[2*k+1] + node[2*k+2];
            end
        end
    end

    assign dn_data = node[0];

endmodule

`default_nettype wire

//--- design/group_mac.sv
/*
 * Group multiply-accumulate
 * GROUP_NB lanes of pixel times weight summed over one window
 */
`timescale 1ns/10ps
`default_nettype none

module group_mac #(
    parameter int GROUP_NB = 4
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    input  wire cnn_data_pkg::pixel_t  [GROUP_NB-1:0]  img,
    input  wire cnn_data_pkg::weight_t [GROUP_NB-1:0]  ker,
    input  wire logic                                  val,
    output cnn_data_pkg::acc_t         [GROUP_NB-1:0]  result
);

    localparam int PROD_WIDTH = cnn_data_pkg::IMG_WIDTH + cnn_data_pkg::KER_WIDTH;

    cnn_data_pkg::pixel_t  [GROUP_NB-1:0] img_q;
    cnn_data_pkg::weight_t [GROUP_NB-1:0] ker_q;
    logic signed [PROD_WIDTH-1:0]         prod [GROUP_NB];
    logic                                 val_q;
    logic                                 prod_val;

    // Operand stage
    always_ff @(posedge clk) begin
        img_q <= img;
        ker_q <= ker;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            val_q    <= 1'b0;
            prod_val <= 1'b0;
        end else begin
            val_q    <= val;
            prod_val <= val_q;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < GROUP_NB; i++) begin
            prod[i] <= img_q[i] * ker_q[i];
            if (rst) begin
                result[i] <= '0;    // New window
            end else if (prod_val) begin
                result[i] <= result[i] + cnn_data_pkg::acc_t'(prod[i]);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/layers.sv
/*
 * Convolution layer engine
 * Per output depth: window MAC, lane sum, max pool, ReLU and rescale,
 * sequenced by an upstream and a downstream state machine
 */
`timescale 1ns/10ps
`default_nettype none

module layers #(
    parameter int DEPTH_NB = 4,
    parameter int GROUP_NB = 4
) (
    input  wire logic                                                clk,
    input  wire logic                                                rst,
    input  wire cnn_cfg_pkg::cfg_write_t                             cfg,
    input  wire logic                                                cfg_valid,
    input  wire cnn_data_pkg::weight_t [DEPTH_NB-1:0][GROUP_NB-1:0]  kernel,
    output logic                                                     kernel_rdy,
    input  wire cnn_data_pkg::pixel_t  [GROUP_NB-1:0]                image,
    input  wire logic                                                image_last,
    input  wire logic                                                image_val,
    output logic                                                     image_rdy,
    output cnn_data_pkg::pixel_t       [DEPTH_NB-1:0]                result,
    output logic                                                     result_val,
    input  wire logic                                                result_rdy
);

    localparam int MAC_LAT = 4;     // Beat accept to hold strobe
    localparam int ADD_LAT = $clog2(GROUP_NB);
    localparam int OPS_LAT = 2;

    typedef enum logic [1:0] {UP_RESET, UP_READY, UP_DONE, UP_CLEAR} up_state_t;
    typedef enum logic [2:0] {
        DN_RESET, DN_READY, DN_ADD, DN_POOL, DN_OPS, DN_CLEAR
    } dn_state_t;

    cnn_cfg_pkg::layer_cfg_t cfg_q;
    up_state_t               up_state;
    up_state_t               up_next;
    dn_state_t               dn_state;
    dn_state_t               dn_next;
    logic                    accept;
    logic [DEPTH_NB-1:0]     mac_rst;
    logic [DEPTH_NB-1:0]     pool_rst;
    logic [7:0]              pool_cnt;
    logic                    last_win;

    logic [MAC_LAT-1:0]      mac_sr;
    logic [ADD_LAT:0]        add_sr;
    logic [OPS_LAT-1:0]      ops_sr;
    logic                    mac_valid;
    logic                    add_valid;
    logic                    pool_valid;
    logic                    rescale_valid;

    cnn_data_pkg::pixel_t [GROUP_NB-1:0]               image_q;
    cnn_data_pkg::acc_t   [DEPTH_NB-1:0][GROUP_NB-1:0] mac_data;
    cnn_data_pkg::acc_t   [DEPTH_NB-1:0][GROUP_NB-1:0] hold;
    cnn_data_pkg::acc_t   [DEPTH_NB-1:0]               add_data;
    cnn_data_pkg::acc_t   [DEPTH_NB-1:0]               pool_data;
    cnn_data_pkg::pixel_t [DEPTH_NB-1:0]               rescale_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (cfg_valid && (cfg.addr == cnn_cfg_pkg::LAYERS_CFG_ADDR)) begin
            cfg_q <= cfg.data;
        end
    end

    assign accept    = image_val && image_rdy;
    assign image_rdy = (up_state == UP_READY);
    assign last_win  = (pool_cnt >= cfg_q.pool_nb);

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= UP_RESET;
            dn_state <= DN_RESET;
        end else begin
            up_state <= up_next;
            dn_state <= dn_next;
        end
    end

    // Upstream side, reopens once the window has reached the pool
    always_comb begin
        up_next = up_state;
        case (up_state)
            UP_RESET: up_next = UP_READY;
            UP_READY: if (accept && image_last) up_next = UP_DONE;
            UP_DONE:  if (mac_valid) up_next = UP_CLEAR;
            UP_CLEAR: if (dn_state == DN_READY) up_next = UP_RESET;
        endcase
    end

    always_comb begin
        dn_next = dn_state;
        case (dn_state)
            DN_RESET: dn_next = DN_READY;
            DN_READY: if (mac_valid) dn_next = DN_ADD;
            DN_ADD:   if (add_valid) dn_next = DN_POOL;
            DN_POOL:  dn_next = last_win ? DN_OPS : DN_READY;
            DN_OPS:   if (rescale_valid) dn_next = DN_CLEAR;
            DN_CLEAR: if (result_rdy) dn_next = DN_RESET;
            default:  dn_next = DN_RESET;
        endcase
    end

    assign result_val = (dn_state == DN_CLEAR);

    always_ff @(posedge clk) begin
        if (rst || (dn_state == DN_RESET)) begin
            pool_cnt <= '0;
        end else if ((dn_state == DN_POOL) && !last_win) begin
            pool_cnt <= pool_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            mac_sr     <= '0;
            add_sr     <= '0;
            pool_valid <= 1'b0;
            ops_sr     <= '0;
        end else begin
            kernel_rdy <= accept;
            mac_sr     <= {mac_sr[MAC_LAT-2:0], accept && image_last};
            add_sr     <= {add_sr[ADD_LAT-1:0], (dn_state == DN_READY) && mac_valid};
            pool_valid <= add_valid;
            ops_sr     <= {ops_sr[OPS_LAT-2:0], pool_valid && last_win};
        end
    end

    assign mac_valid     = mac_sr[MAC_LAT-1];
    assign add_valid     = add_sr[ADD_LAT];
    assign rescale_valid = ops_sr[OPS_LAT-1];

    // Restarts replicated per depth to keep fanout local
    always_ff @(posedge clk) begin
        mac_rst  <= {DEPTH_NB{up_state == UP_RESET}};
        pool_rst <= {DEPTH_NB{dn_state == DN_RESET}};
    end

    always_ff @(posedge clk) begin
        image_q <= image;
        if (mac_valid) hold <= mac_data;
        if (rescale_valid) result <= rescale_data;
    end

    for (genvar i = 0; i < DEPTH_NB; i++) begin : g_depth
        group_mac #(
            .GROUP_NB (GROUP_NB)
        ) u_group_mac (
            .clk    (clk),
            .rst    (mac_rst[i]),
            .img    (image_q),
            .ker    (kernel[i]),
            .val    (kernel_rdy),
            .result (mac_data[i])
        );

        group_add #(
            .GROUP_NB (GROUP_NB)
        ) u_group_add (
            .clk     (clk),
            .up_data (hold[i]),
            .dn_data (add_data[i])
        );

        pool u_pool (
            .clk      (clk),
            .restart  (pool_rst[i]),
            .up_data  (add_data[i]),
            .up_valid (add_valid),
            .dn_data  (pool_data[i])
        );

        relu_rescale u_relu_rescale (
            .clk     (clk),
            .bypass  (cfg_q.bypass),
            .shift   (cfg_q.shift),
            .up_data (pool_data[i]),
            .dn_data (rescale_data[i])
        );
    end

endmodule

`default_nettype wire

//--- design/pool.sv
/*
 * Max pool
 * Running signed maximum over the windows of one pooling group
 */
`timescale 1ns/10ps
`default_nettype none

module pool (
    input  wire logic                clk,
    input  wire logic                restart,
    input  wire cnn_data_pkg::acc_t  up_data,
    input  wire logic                up_valid,
    output cnn_data_pkg::acc_t       dn_data
);

    logic fresh;    // Next valid input loads unconditionally

    always_ff @(posedge clk) begin
        if (restart) begin
            fresh <= 1'b1;
        end else if (up_valid) begin
            fresh <= 1'b0;
            if (fresh || (up_data > dn_data)) begin
                dn_data <= up_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/relu_rescale.sv
/*
 * Activation and rescale
 * Optional ReLU, then arithmetic right shift saturated to pixel width
 */
`timescale 1ns/10ps
`default_nettype none

module relu_rescale (
    input  wire logic                clk,
    input  wire logic                bypass,
    input  wire logic [7:0]          shift,
    input  wire cnn_data_pkg::acc_t  up_data,
    output cnn_data_pkg::pixel_t     dn_data
);

    localparam cnn_data_pkg::acc_t PIX_MAX =
        cnn_data_pkg::acc_t'((1 << (cnn_data_pkg::IMG_WIDTH - 1)) - 1);
    localparam cnn_data_pkg::acc_t PIX_MIN =
        cnn_data_pkg::acc_t'(-(1 << (cnn_data_pkg::IMG_WIDTH - 1)));

    cnn_data_pkg::acc_t relu_q;
    cnn_data_pkg::acc_t shifted;

    always_ff @(posedge clk) begin
        if (!bypass && up_data[cnn_data_pkg::ACC_WIDTH-1]) begin
            relu_q <= '0;
        end else begin
            relu_q <= up_data;
        end
    end

    assign shifted = relu_q >>> shift;  // Sign fill

    always_ff @(posedge clk) begin
        if (shifted > PIX_MAX) begin
            dn_data <= cnn_data_pkg::pixel_t'(PIX_MAX);
        end else if (shifted < PIX_MIN) begin
            dn_data <= cnn_data_pkg::pixel_t'(PIX_MIN);
        end else begin
            dn_data <= cnn_data_pkg::pixel_t'(shifted);
        end
    end

endmodule

`default_nettype wire

//--- dv/layers_assert.sv
/*
 * Layer engine handshake assertions
 * Bound into the layer engine top level
 */
`timescale 1ns/10ps
`default_nettype none

module layers_assert #(
    parameter int DEPTH_NB = 4
) (
    input wire logic                                  clk,
    input wire logic                                  rst,
    input wire logic                                  image_val,
    input wire logic                                  image_rdy,
    input wire logic                                  kernel_rdy,
    input wire cnn_data_pkg::pixel_t [DEPTH_NB-1:0]   result,
    input wire logic                                  result_val,
    input wire logic                                  result_rdy
);

    int fail_count = 0;

    // A pending result is frozen until taken
    result_hold: assert property (@(posedge clk) disable iff (rst)
        (result_val && !result_rdy) |=> (result_val && $stable(result)))
    else begin
        fail_count++;
        $error("result changed while result_rdy was low");
    end

    kernel_strobe: assert property (@(posedge clk) disable iff (rst)
        kernel_rdy == $past(image_val && image_rdy))
    else begin
        fail_count++;
        $error("kernel_rdy not aligned to the cycle after an accepted beat");
    end

    no_image_on_result: assert property (@(posedge clk) disable iff (rst)
        result_val |-> !image_rdy)
    else begin
        fail_count++;
        $error("image_rdy high while a result is pending");
    end

endmodule

bind layers layers_assert #(
    .DEPTH_NB (DEPTH_NB)
) u_layers_assert (
    .clk        (clk),
    .rst        (rst),
    .image_val  (image_val),
    .image_rdy  (image_rdy),
    .kernel_rdy (kernel_rdy),
    .result     (result),
    .result_val (result_val),
    .result_rdy (result_rdy)
);

`default_nettype wire

//--- dv/tb_layers.sv
/*
 * Layer engine testbench
 * Table of layer configs streamed against a sum, pool and rescale model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_layers;

    localparam int DEPTH_NB      = 2;
    localparam int GROUP_NB      = 4;
    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int MAX_BEATS     = 8;
    localparam int STEP_WAIT     = 40;  // Bound on one handshake wait
    localparam int WINDOW_MARGIN = 20;
    localparam int CASE_MARGIN   = 40;

    // sign_mode 0 mixed, 1 products <= 0, 2 products >= 0
    typedef struct packed {
        logic        bypass;
        logic [7:0]  pool_nb;
        logic [7:0]  shift;
        logic [7:0]  beats;
        logic [7:0]  stall;
        logic [1:0]  sign_mode;
        logic [15:0] pix_lim;
        logic [15:0] ker_lim;
    } test_case_t;

    localparam int NUM_CASES = 9;
    localparam test_case_t CASES [NUM_CASES] = '{
        '{1'b0, 8'd0, 8'd2, 8'd3, 8'd0, 2'd0, 16'd100,   16'd100},   // Single window
        '{1'b0, 8'd2, 8'd3, 8'd4, 8'd0, 2'd0, 16'd100,   16'd100},   // Max of three
        '{1'b1, 8'd0, 8'd1, 8'd2, 8'd0, 2'd1, 16'd60,    16'd60},
        '{1'b0, 8'd1, 8'd1, 8'd2, 8'd0, 2'd1, 16'd60,    16'd60},    // Clamped to zero
        '{1'b0, 8'd0, 8'd0, 8'd4, 8'd0, 2'd2, 16'd30000, 16'd30000},
        '{1'b1, 8'd1, 8'd2, 8'd4, 8'd0, 2'd1, 16'd30000, 16'd30000}, // Negative limit
        '{1'b0, 8'd1, 8'd2, 8'd3, 8'd7, 2'd0, 16'd100,   16'd100},   // Result stall
        '{1'b1, 8'd3, 8'd4, 8'd5, 8'd3, 2'd0, 16'd1000,  16'd1000},
        '{1'b0, 8'd0, 8'd0, 8'd1, 8'd0, 2'd2, 16'd50,    16'd50}
    };

    logic                                               clk = 1'b0;
    logic                                               rst;
    cnn_cfg_pkg::cfg_write_t                            cfg;
    logic                                               cfg_valid;
    cnn_data_pkg::weight_t [DEPTH_NB-1:0][GROUP_NB-1:0] kernel;
    logic                                               kernel_rdy;
    cnn_data_pkg::pixel_t  [GROUP_NB-1:0]               image;
    logic                                               image_last;
    logic                                               image_val;
    logic                                               image_rdy;
    cnn_data_pkg::pixel_t  [DEPTH_NB-1:0]               result;
    logic                                               result_val;
    logic                                               result_rdy;

    logic [31:0] lcg_state = 32'd67548;
    int          win_pix [MAX_BEATS][GROUP_NB];
    int          win_ker [MAX_BEATS][DEPTH_NB][GROUP_NB];
    longint      win_sum [DEPTH_NB];
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    layers #(
        .DEPTH_NB (DEPTH_NB),
        .GROUP_NB (GROUP_NB)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .cfg_valid  (cfg_valid),
        .kernel     (kernel),
        .kernel_rdy (kernel_rdy),
        .image      (image),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result     (result),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Magnitude up to lim, or a signed value in -lim..lim
    function automatic int scaled_value(input int lim, input bit magnitude);
        int r;
        r = int'(lcg_next() >> 8);
        if (magnitude) begin
            return r % (lim + 1);
        end
        return (r % (2 * lim + 1)) - lim;
    endfunction

    function automatic longint rescale_model(input longint sum, input bit bypass, input int shift);
        longint v;
        longint lim;
        lim = longint'(1) <<< (cnn_data_pkg::IMG_WIDTH - 1);
        v = (!bypass && sum < 0) ? 0 : sum;
        v = v >>> shift;
        if (v > lim - 1) begin
            v = lim - 1;
        end else if (v < -lim) begin
            v = -lim;
        end
        return v;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        int i;
        total = 2 * RESET_CYCLES;
        for (i = 0; i < NUM_CASES; i++) begin
            total += (int'(CASES[i].pool_nb) + 1) * (int'(CASES[i].beats) + WINDOW_MARGIN);
            total += int'(CASES[i].stall) + CASE_MARGIN;
        end
        return 2 * total;
    endfunction

    task automatic fill_window(input test_case_t tc);
        int b;
        int l;
        int d;
        int k;
        for (d = 0; d < DEPTH_NB; d++) begin
            win_sum[d] = 0;
        end
        for (b = 0; b < int'(tc.beats); b++) begin
            for (l = 0; l < GROUP_NB; l++) begin
                win_pix[b][l] = scaled_value(int'(tc.pix_lim), tc.sign_mode != 2'd0);
                for (d = 0; d < DEPTH_NB; d++) begin
                    k = scaled_value(int'(tc.ker_lim), tc.sign_mode != 2'd0);
                    win_ker[b][d][l] = (tc.sign_mode == 2'd1) ? -k : k;
                    win_sum[d] += longint'(win_pix[b][l]) * longint'(win_ker[b][d][l]);
                end
            end
        end
    endtask

    // Kernel of a beat goes out on the falling edge after its acceptance
    task automatic send_window(input int idx, input int beats);
        int  b;
        int  l;
        int  d;
        int  pend;
        int  waited;
        bit  pending;
        b = 0;
        pend = 0;
        waited = 0;
        pending = 1'b0;
        while ((b < beats || pending) && waited < STEP_WAIT) begin
            @(negedge clk);
            if (pending) begin
                for (d = 0; d < DEPTH_NB; d++) begin
                    for (l = 0; l < GROUP_NB; l++) begin
                        kernel[d][l] = cnn_data_pkg::weight_t'(win_ker[pend][d][l]);
                    end
                end
                pending = 1'b0;
            end
            if (b < beats) begin
                for (l = 0; l < GROUP_NB; l++) begin
                    image[l] = cnn_data_pkg::pixel_t'(win_pix[b][l]);
                end
                image_last = (b == beats - 1);
                image_val = 1'b1;
                if (image_rdy) begin    // Taken on the next rising edge
                    pending = 1'b1;
                    pend = b;
                    b++;
                    waited = 0;
                end else begin
                    waited++;
                end
            end else begin
                image_val = 1'b0;
                image_last = 1'b0;
            end
        end
        if (b < beats) begin
            image_val = 1'b0;
            other_errors++;
            $display("Case %0d: image beat %0d was never accepted", idx, b);
        end
    endtask

    task automatic run_case(input int idx);
        test_case_t                          tc;
        longint                              best [DEPTH_NB];
        cnn_data_pkg::pixel_t [DEPTH_NB-1:0] expected;
        cnn_data_pkg::pixel_t [DEPTH_NB-1:0] held;
        int                                  w;
        int                                  d;
        int                                  waited;
        tc = CASES[idx];
        waited = 0;
        while (!image_rdy && waited < STEP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!image_rdy) begin
            other_errors++;
            $display("Case %0d: engine never returned to idle", idx);
        end
        cfg.addr = cnn_cfg_pkg::LAYERS_CFG_ADDR;
        cfg.data = '0;
        cfg.data.bypass = tc.bypass;
        cfg.data.pool_nb = tc.pool_nb;
        cfg.data.shift = tc.shift;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        result_rdy = (tc.stall == 8'd0);

        for (w = 0; w <= int'(tc.pool_nb); w++) begin
            fill_window(tc);
            for (d = 0; d < DEPTH_NB; d++) begin
                if (w == 0 || win_sum[d] > best[d]) begin
                    best[d] = win_sum[d];
                end
            end
            send_window(idx, int'(tc.beats));
        end
        for (d = 0; d < DEPTH_NB; d++) begin
            expected[d] = cnn_data_pkg::pixel_t'(rescale_model(best[d], tc.bypass, tc.shift));
        end

        waited = 0;
        while (!result_val && waited < STEP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!result_val) begin
            other_errors++;
            $display("Case %0d: result_val never rose", idx);
        end else begin
            held = result;
            if (tc.stall != 8'd0) begin
                image_last = 1'b0;
                image_val = 1'b1;   // Offered beat must not be taken
            end
            for (waited = 0; waited < int'(tc.stall); waited++) begin
                @(negedge clk);
                checks++;
                assert (result == held) else begin
                    value_errors++;
                    $display("[ERROR] result moved in stall: got %h held %h", result, held);
                end
                assert (result_val && !image_rdy && !kernel_rdy) else begin
                    other_errors++;
                    $display("Case %0d: handshake changed while result_rdy was low", idx);
                end
            end
            image_val = 1'b0;
            result_rdy = 1'b1;
            for (d = 0; d < DEPTH_NB; d++) begin
                checks++;
                assert (result[d] == expected[d]) else begin
                    value_errors++;
                    $display("[ERROR] case %0d result[%0d]: got %h expected %h",
                             idx, d, result[d], expected[d]);
                end
            end
            @(negedge clk);
            result_rdy = 1'b0;
            assert (!result_val) else begin
                other_errors++;
                $display("Case %0d: result_val stayed high after acceptance", idx);
            end
        end
    endtask

    task automatic report_counts();
        $display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, dut.u_layers_assert.fail_count);
    endtask

    initial begin : main
        int i;
        rst = 1'b1;
        cfg = '0;
        cfg_valid = 1'b0;
        kernel = '0;
        image = '0;
        image_last = 1'b0;
        image_val = 1'b0;
        result_rdy = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checks++;
        assert (!result_val && !kernel_rdy) else begin
            other_errors++;
            $display("result_val or kernel_rdy high right after reset");
        end
        repeat (2) begin
            if (!image_rdy) @(negedge clk);
        end
        assert (image_rdy) else begin
            other_errors++;
            $display("image_rdy did not rise within two cycles of reset");
        end

        for (i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        report_counts();
        if (value_errors + other_errors + dut.u_layers_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(longint'(watchdog_cycles()) * CLK_PERIOD);
        $display("Run did not complete within %0d cycles", watchdog_cycles());
        report_counts();
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/cnn_cfg_pkg.sv
design/cnn_data_pkg.sv
design/group_mac.sv
design/group_add.sv
design/pool.sv
design/relu_rescale.sv
design/layers.sv
dv/layers_assert.sv
dv/tb_layers.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the layer engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_layers -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_layers +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
